// File: draw_core.f
+incdir+verilog
+incdir+tb
verilog/draw_pkg.sv
verilog/raster_if.sv
verilog/raster_counter.sv
verilog/seg_glyph.sv
verilog/pixel_writer.sv
verilog/draw_fsm.sv
verilog/draw_core.sv
tb/tb_draw_core.sv

// File: tb/draw_input.txt
# cmd (hex)  data_word (hex)  max done delay (dec)  expected writes (dec)
# Writes of zero mean the core must stay idle for 200 cycles.
0 00000000 0 384000
1 00000000 0 3265
5 01234567 0 2304
5 89ABCDEF 0 2304
1 00000000 3 3265
5 01234567 5 2304
5 89ABCDEF 2 2304
5 F0E1D2C3 7 2304
7 00000000 0 0
1 00000000 1 3265

// File: tb/tb_draw_model.svh
`ifndef TB_DRAW_MODEL_SVH
`define TB_DRAW_MODEL_SVH

////////////////////////////////////////////////////////////
// Expected SDRAM writes.
////////////////////////////////////////////////////////////
typedef struct packed {
  pix_addr_t addr;
  pixel_t    data;
} wr_pair_t;

wr_pair_t    exp_q[$];          // Writes still to come, in order.
logic [15:0] lfsr_q = 16'd55;   // Delay generator state.
int          err_cnt;           // Failed checks in the running test.
int          wr_cnt;            // Writes accepted in the running test.
int          done_cnt;          // Done pulses in the running test.
bit          req_seen;
int          pass_cnt;
int          fail_cnt;

// Galois LFSR for x^16 + x^14 + x^13 + x^11 + 1.
function automatic logic [15:0] lfsr_next(logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// Done delay from 0 to max with one LFSR step per bit.
function automatic int pick_delay(int max_delay);
  int bits;
  int value;
  bits  = 0;
  value = 0;
  while ((1 << bits) <= max_delay) begin
    bits++;
  end
  for (int i = 0; i < bits; i++) begin
    value  = (value << 1) | lfsr_q[0];
    lfsr_q = lfsr_next(lfsr_q);
  end
  return value % (max_delay + 1);
endfunction

// Standard hex shapes with segment a in bit 0.
function automatic logic [6:0] seg_bits(logic [3:0] dig);
  logic [6:0] t [16];
  t = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
  return t[dig];
endfunction

// Pixel r along x and c along y of a 24 x 12 cell.
function automatic logic glyph_lit(logic [3:0] dig, int r, int c);
  logic [6:0] s;
  logic       bar;
  logic       left;
  logic       right;
  s     = seg_bits(dig);
  bar   = (c >= 2) && (c <= 9);
  left  = (c <= 1);
  right = (c >= 10);
  return (s[0] && r <= 1 && bar)                 // a
      || (s[1] && r >= 2 && r <= 10 && right)    // b
      || (s[2] && r >= 13 && r <= 21 && right)   // c
      || (s[3] && r >= 22 && bar)                // d
      || (s[4] && r >= 13 && r <= 21 && left)    // e
      || (s[5] && r >= 2 && r <= 10 && left)     // f
      || (s[6] && (r == 11 || r == 12) && bar);  // g
endfunction

// One straight line stepping 1 along x or a full row along y.
task automatic add_line(int x, int y, int step, int count, pixel_t color);
  for (int i = 0; i < count; i++) begin
    exp_q.push_back('{pix_addr_t'(y * `SCREEN_W + x + i * step), color});
  end
endtask

task automatic build_expected(logic [3:0] c, logic [31:0] d);
  logic [3:0]  dig;
  logic [31:0] word;
  exp_q.delete();
  word = d;
  if (c == 4'd0) begin
    for (int i = 0; i < `PIXELS; i++) begin
      exp_q.push_back('{pix_addr_t'(i), `COLOR_BLACK});
    end
  end else if (c == 4'd1) begin
    add_line(`FRAME_X0, `FRAME_Y0, 1, `FRAME_X1 - `FRAME_X0 + 1, `COLOR_GREEN);  // Top.
    add_line(`FRAME_X0, `FRAME_Y1, 1, `FRAME_X1 - `FRAME_X0 + 1, `COLOR_GREEN);  // Bottom.
    add_line(`FRAME_X0, `FRAME_Y0, `SCREEN_W, `FRAME_Y1 - `FRAME_Y0 + 1, `COLOR_GREEN);
    add_line(`FRAME_X1, `FRAME_Y0, `SCREEN_W, `FRAME_Y1 - `FRAME_Y0 + 1, `COLOR_GREEN);
    add_line(`FRAME_XM, `FRAME_Y0, `SCREEN_W, `FRAME_Y1 - `FRAME_Y0 + 1, `COLOR_YELLOW);
  end else if (c == 4'd5) begin
    for (int k = 0; k < `DIGITS; k++) begin
      dig  = word[31:28];  // Leftmost nibble first.
      word = word << 4;
      for (int y = 0; y < `GLYPH_C; y++) begin
        for (int x = 0; x < `GLYPH_R; x++) begin
          exp_q.push_back('{pix_addr_t'((`CNT_Y0 + `GLYPH_C * k + y) * `SCREEN_W + `CNT_X0 + x),
                            glyph_lit(dig, x, y) ? `COLOR_GREEN : `COLOR_BLACK});
        end
      end
    end
  end
endtask

`endif

// File: tb/tb_draw_core.sv
`include "draw_settings.svh"

module tb_draw_core;

  import draw_pkg::*;

  logic        clk;
  logic        rst_n;
  logic        en;
  logic [3:0]  cmd;
  logic [31:0] data_word;
  logic        wr_done;
  logic        draw_done;
  pix_addr_t   wr_addr;
  pixel_t      wr_data;
  logic        wr_req;

  logic [3:0]  t_cmd[$];     // Tests from the data file.
  logic [31:0] t_data[$];
  int          t_delay[$];
  int          t_writes[$];

  int          cur_max;      // Done delay bound of the running test.
  int          cycle_cnt;
  int          cycle_limit;  // Zero until the file is read.
  bit          busy;
  int          wait_cnt;
  bit          held;
  pix_addr_t   held_addr;
  pixel_t      held_data;

  `include "tb_draw_model.svh"

  draw_core i_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .en        (en),
    .cmd       (cmd),
    .data_word (data_word),
    .wr_done   (wr_done),
    .draw_done (draw_done),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data),
    .wr_req    (wr_req)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // SDRAM responder and timeout.
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    int d;
    if (!rst_n) begin
      wr_done <= 1'b0;
      busy = 1'b0;
    end else if (wr_done) begin
      wr_done <= 1'b0;  // Request drops on this edge.
    end else if (busy) begin
      if (wait_cnt == 0) begin
        wr_done <= 1'b1;
        busy = 1'b0;
      end else begin
        wait_cnt--;
      end
    end else if (wr_req) begin
      d = pick_delay(cur_max);
      if (d == 0) begin
        wr_done <= 1'b1;
      end else begin
        busy = 1'b1;
        wait_cnt = d - 1;
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      $display("Timeout: no result after %0d cycles", cycle_limit);
      $display("tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write monitor.
  ////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    wr_pair_t want;
    if (rst_n) begin
      if (wr_req) req_seen = 1'b1;
      if (draw_done) done_cnt++;
      if (held) begin  // Waiting request must not move.
        assert (wr_req && wr_addr == held_addr && wr_data == held_data)
          else begin
            $display("Error %0t: request moved to %h/%h while waiting on %h/%h",
                     $time, wr_addr, wr_data, held_addr, held_data);
            err_cnt++;
          end
      end
      held      = wr_req && !wr_done;
      held_addr = wr_addr;
      held_data = wr_data;
      if (wr_req && wr_done) begin
        assert (exp_q.size() > 0)
          else begin
            $display("Unexpected write to address %h after the last expected one", wr_addr);
            err_cnt++;
          end
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          wr_cnt++;
          assert (wr_addr == want.addr && wr_data == want.data)
            else begin
              $display("Error %0t: write %0d got addr %h data %h, expected addr %h data %h",
                       $time, wr_cnt, wr_addr, wr_data, want.addr, want.data);
              err_cnt++;
            end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Test sequence.
  ////////////////////////////////////////////////////////////
  task automatic read_tests(output bit ok);
    int          fd;
    int          n;
    string       line;
    logic [3:0]  c;
    logic [31:0] d;
    int          dl;
    int          w;
    ok = 1'b0;
    fd = $fopen("tb/draw_input.txt", "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 1 && line[0] != "#") begin  // Skip comments.
          n = $sscanf(line, "%h %h %d %d", c, d, dl, w);
          if (n == 4) begin
            t_cmd.push_back(c);
            t_data.push_back(d);
            t_delay.push_back(dl);
            t_writes.push_back(w);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_one_test(int idx);
    build_expected(t_cmd[idx], t_data[idx]);
    err_cnt  = 0;
    wr_cnt   = 0;
    done_cnt = 0;
    req_seen = 1'b0;
    cur_max  = t_delay[idx];
    assert (exp_q.size() == t_writes[idx])
      else begin
        $display("Error %0t: model gives %0d writes, data file %0d",
                 $time, exp_q.size(), t_writes[idx]);
        err_cnt++;
      end
    @(posedge clk);
    cmd       <= t_cmd[idx];
    data_word <= t_data[idx];
    en        <= 1'b1;
    if (t_writes[idx] == 0) begin
      repeat (200) @(posedge clk);  // Unknown code stays idle.
      en <= 1'b0;
      @(negedge clk);  // Monitor has taken the last edge.
      assert (!req_seen && done_cnt == 0)
        else begin
          $display("Command %0h started a write or pulsed done", t_cmd[idx]);
          err_cnt++;
        end
    end else begin
      while (!wr_req) @(posedge clk);
      en <= 1'b0;  // Command is latched.
      while (!draw_done) @(posedge clk);
      repeat (8) @(posedge clk);
      @(negedge clk);
      assert (done_cnt == 1 && exp_q.size() == 0)
        else begin
          $display("Command %0h ended with %0d done pulses and %0d writes missing",
                   t_cmd[idx], done_cnt, exp_q.size());
          err_cnt++;
        end
    end
    $display("Test %0d cmd %0h data %h delay %0d: %0d writes, %0d errors, %s",
             idx + 1, t_cmd[idx], t_data[idx], t_delay[idx], wr_cnt, err_cnt,
             (err_cnt == 0) ? "ok" : "FAIL");
    if (err_cnt == 0) pass_cnt++;
    else fail_cnt++;
  endtask

  initial begin
    bit ok;
    clk = 1'b0;
    rst_n = 1'b0;
    en = 1'b0;
    cmd = 4'd0;
    data_word = 32'd0;
    wr_done = 1'b0;
    read_tests(ok);
    if (!ok) begin
      $display("Cannot open the test data file tb/draw_input.txt");
      $display("tests failed");
    end else begin
      cycle_limit = 1000;
      foreach (t_writes[i]) cycle_limit += t_writes[i] * (t_delay[i] + 4);
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      assert (!wr_req && !draw_done && wr_addr == '0)  // Idle after reset.
        else begin
          $display("Error %0t: after reset wr_req %b draw_done %b wr_addr %h",
                   $time, wr_req, draw_done, wr_addr);
          fail_cnt++;
        end
      $display("Test 0 reset: %s", (fail_cnt == 0) ? "ok" : "FAIL");
      if (fail_cnt == 0) pass_cnt++;
      foreach (t_cmd[i]) run_one_test(i);
      $display("Summary: %0d run, %0d passed, %0d failed",
               pass_cnt + fail_cnt, pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("all tests passed");
      end else begin
        $display("tests failed");
      end
    end
    $finish;
  end

endmodule

// File: verilog/draw_core.sv
module draw_core (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,
  input  logic [3:0]          cmd,
  input  logic [31:0]         data_word,
  input  logic                wr_done,
  output logic                draw_done,
  output draw_pkg::pix_addr_t wr_addr,
  output draw_pkg::pixel_t    wr_data,
  output logic                wr_req
);

  import draw_pkg::*;

  nibble_t     digit;       // Digit of the current cell.
  logic        lit;         // Glyph pixel on.
  logic        pix_start;
  logic        pix_taken;
  pix_addr_t   pix_base;
  logic [15:0] pix_stride;
  pixel_t      pix_color;
  logic [15:0] pix_inner;
  logic [15:0] pix_outer;

  raster_if rif ();

  ////////////////////////////////////////////////////////////
  // Sequencer and raster walk.
  ////////////////////////////////////////////////////////////
  draw_fsm i_fsm (
    .clk        (clk),
    .rst_n      (rst_n),
    .en         (en),
    .cmd        (cmd),
    .data_word  (data_word),
    .rw         (rif.master),
    .lit        (lit),
    .digit      (digit),
    .pix_taken  (pix_taken),
    .pix_start  (pix_start),
    .pix_base   (pix_base),
    .pix_stride (pix_stride),
    .pix_color  (pix_color),
    .pix_inner  (pix_inner),
    .pix_outer  (pix_outer),
    .draw_done  (draw_done)
  );

  raster_counter i_raster (
    .clk   (clk),
    .rst_n (rst_n),
    .rw    (rif.counter)
  );

  // Cell position straight from the raster indices.
  seg_glyph i_glyph (
    .digit (digit),
    .row   (rif.inner_idx[4:0]),
    .col   (rif.outer_idx[3:0]),
    .lit   (lit)
  );

  ////////////////////////////////////////////////////////////
  // SDRAM side.
  ////////////////////////////////////////////////////////////
  pixel_writer i_writer (
    .clk        (clk),
    .rst_n      (rst_n),
    .pix_start  (pix_start),
    .pix_base   (pix_base),
    .pix_stride (pix_stride),
    .pix_color  (pix_color),
    .pix_inner  (pix_inner),
    .pix_outer  (pix_outer),
    .pix_taken  (pix_taken),
    .wr_req     (wr_req),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .wr_done    (wr_done)
  );

endmodule

// File: verilog/draw_fsm.sv
`include "draw_settings.svh"

module draw_fsm (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                en,
  input  logic [3:0]          cmd,
  input  logic [31:0]         data_word,
  raster_if.master            rw,
  input  logic                lit,
  output draw_pkg::nibble_t   digit,
  input  logic                pix_taken,
  output logic                pix_start,
  output draw_pkg::pix_addr_t pix_base,
  output logic [15:0]         pix_stride,
  output draw_pkg::pixel_t    pix_color,
  output logic [15:0]         pix_inner,
  output logic [15:0]         pix_outer,
  output logic                draw_done
);

  import draw_pkg::*;

  enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT} state;

  draw_cmd_e   cmd_q;      // Command of the running job.
  logic [31:0] data_q;     // Counter word of the running job.
  logic [2:0]  shape_idx;  // Line or digit cell being drawn.
  draw_cmd_e   load_cmd;
  logic [2:0]  load_idx;
  logic        start;
  logic        shape_end;
  logic        final_shape;

  ////////////////////////////////////////////////////////////
  // Shape list.
  ////////////////////////////////////////////////////////////
  function automatic logic [15:0] inner_len_of(draw_cmd_e c, logic [2:0] idx);
    case (c)
      CMD_CLEAR: return 16'(`SCREEN_W);  // One full row.
      CMD_FRAME: return (idx < 3'd2) ? 16'(`FRAME_X1 - `FRAME_X0 + 1)
                                     : 16'(`FRAME_Y1 - `FRAME_Y0 + 1);
      default:   return 16'(`GLYPH_R);
    endcase
  endfunction

  function automatic logic [15:0] outer_len_of(draw_cmd_e c);
    case (c)
      CMD_CLEAR: return 16'(`SCREEN_H);  // Rows stack up to 384000 pixels.
      CMD_FRAME: return 16'd1;           // Lines are one run.
      default:   return 16'(`GLYPH_C);
    endcase
  endfunction

  function automatic pix_addr_t base_of(draw_cmd_e c, logic [2:0] idx);
    case (c)
      CMD_CLEAR: return '0;
      CMD_FRAME: begin
        case (idx)
          3'd0:    return pix_addr_t'(`FRAME_Y0 * `SCREEN_W + `FRAME_X0);  // Top.
          3'd1:    return pix_addr_t'(`FRAME_Y1 * `SCREEN_W + `FRAME_X0);  // Bottom.
          3'd2:    return pix_addr_t'(`FRAME_Y0 * `SCREEN_W + `FRAME_X0);  // Left.
          3'd3:    return pix_addr_t'(`FRAME_Y0 * `SCREEN_W + `FRAME_X1);  // Right.
          default: return pix_addr_t'(`FRAME_Y0 * `SCREEN_W + `FRAME_XM);  // Divider.
        endcase
      end
      default:   return pix_addr_t'((`CNT_Y0 + `GLYPH_C * idx) * `SCREEN_W + `CNT_X0);
    endcase
  endfunction

  function automatic logic [2:0] last_idx_of(draw_cmd_e c);
    case (c)
      CMD_CLEAR: return 3'd0;
      CMD_FRAME: return 3'd4;
      default:   return 3'(`DIGITS - 1);
    endcase
  endfunction

  function automatic logic cmd_valid(logic [3:0] c);
    return (c == CMD_CLEAR) || (c == CMD_FRAME) || (c == CMD_COUNTER);
  endfunction

  ////////////////////////////////////////////////////////////
  // Raster control.
  ////////////////////////////////////////////////////////////
  assign start       = (state == S_IDLE) && en && cmd_valid(cmd);
  assign shape_end   = (state == S_WAIT) && pix_taken && rw.last;
  assign final_shape = (shape_idx == last_idx_of(cmd_q));

  // Lengths go with the shape being loaded.
  assign load_cmd = (state == S_IDLE) ? draw_cmd_e'(cmd) : cmd_q;
  assign load_idx = (state == S_IDLE) ? 3'd0 : shape_idx + 3'd1;

  assign rw.load      = start || (shape_end && !final_shape);
  assign rw.step      = (state == S_WAIT) && pix_taken && !rw.last;
  assign rw.inner_len = inner_len_of(load_cmd, load_idx);
  assign rw.outer_len = outer_len_of(load_cmd);

  // Most significant nibble in cell 0.
  assign digit = data_q[4 * (`DIGITS - 1 - shape_idx) +: 4];

  ////////////////////////////////////////////////////////////
  // Pixel request.
  ////////////////////////////////////////////////////////////
  assign pix_start  = (state == S_ISSUE);
  assign pix_base   = base_of(cmd_q, shape_idx);
  assign pix_stride = (cmd_q == CMD_FRAME && shape_idx >= 3'd2) ? 16'(`SCREEN_W) : 16'd1;
  assign pix_inner  = rw.inner_idx;
  assign pix_outer  = rw.outer_idx;

  always_comb begin
    case (cmd_q)
      CMD_CLEAR: pix_color = `COLOR_BLACK;
      CMD_FRAME: pix_color = (shape_idx == 3'd4) ? `COLOR_YELLOW : `COLOR_GREEN;
      default:   pix_color = lit ? `COLOR_GREEN : `COLOR_BLACK;  // Glyph on black.
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Sequencer.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= S_IDLE;
      cmd_q     <= CMD_CLEAR;
      shape_idx <= 3'd0;
      draw_done <= 1'b0;
    end else begin
      draw_done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            cmd_q     <= draw_cmd_e'(cmd);
            shape_idx <= 3'd0;
            state     <= S_ISSUE;
          end
        end
        S_ISSUE: state <= S_WAIT;  // One pixel in flight.
        S_WAIT: begin
          if (pix_taken) begin
            if (!rw.last) begin
              state <= S_ISSUE;
            end else if (final_shape) begin
              draw_done <= 1'b1;  // Job finished.
              state     <= S_IDLE;
            end else begin
              shape_idx <= shape_idx + 3'd1;  // Next shape.
              state     <= S_ISSUE;
            end
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      data_q <= data_word;
    end
  end

  // Done is a single pulse.
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    draw_done |=> !draw_done)
    else $error("draw_done high two cycles in a row");

endmodule

// File: verilog/draw_pkg.sv
package draw_pkg;

  ////////////////////////////////////////////////////////////
  // Command codes on the cmd port.
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    CMD_CLEAR   = 4'd0,  // Black over the whole panel.
    CMD_FRAME   = 4'd1,  // Fixed green and yellow lines.
    CMD_COUNTER = 4'd5   // Eight hex digits of data_word.
  } draw_cmd_e;

  // SDRAM word address.
  // Bank, row and column packed into 24 bits.
  typedef logic [23:0] pix_addr_t;

  // One RGB565 pixel.
  typedef logic [15:0] pixel_t;

  // One hex digit of the counter word.
  typedef logic [3:0] nibble_t;

endpackage

// File: verilog/draw_settings.svh
`ifndef DRAW_SETTINGS_SVH
`define DRAW_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Panel geometry, portrait 480 x 800.
////////////////////////////////////////////////////////////
`define SCREEN_W 480  // Pixels per row.
`define SCREEN_H 800  // Rows.
`define PIXELS   (`SCREEN_W * `SCREEN_H)

// Fixed frame lines.
`define FRAME_X0 10   // Left edge.
`define FRAME_X1 470  // Right edge.
`define FRAME_XM 240  // Centre divider.
`define FRAME_Y0 10   // Top edge.
`define FRAME_Y1 790  // Bottom edge.

////////////////////////////////////////////////////////////
// Counter readout.
////////////////////////////////////////////////////////////
`define CNT_X0  210  // Origin of first cell.
`define CNT_Y0  680
`define GLYPH_R 24   // Cell extent along x.
`define GLYPH_C 12   // Cell extent along y.
`define DIGITS  8    // Hex digits in a data word.

// RGB565 colors.
`define COLOR_BLACK  16'h0000
`define COLOR_GREEN  16'h07E0
`define COLOR_YELLOW 16'hFFE0

`endif

// File: verilog/pixel_writer.sv
`include "draw_settings.svh"

module pixel_writer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                pix_start,
  input  draw_pkg::pix_addr_t pix_base,
  input  logic [15:0]         pix_stride,
  input  draw_pkg::pixel_t    pix_color,
  input  logic [15:0]         pix_inner,
  input  logic [15:0]         pix_outer,
  output logic                pix_taken,
  output logic                wr_req,
  output draw_pkg::pix_addr_t wr_addr,
  output draw_pkg::pixel_t    wr_data,
  input  logic                wr_done
);

  import draw_pkg::*;

  pix_addr_t addr_next;
  logic      accept;

  ////////////////////////////////////////////////////////////
  // Address of the requested pixel.
  ////////////////////////////////////////////////////////////
  assign addr_next = pix_base
                   + pix_addr_t'(pix_inner) * pix_addr_t'(pix_stride)
                   + pix_addr_t'(pix_outer) * pix_addr_t'(`SCREEN_W);

  // New pixel only when the bus is free.
  assign accept = pix_start && !wr_req;

  ////////////////////////////////////////////////////////////
  // SDRAM request and done.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_req    <= 1'b0;
      wr_addr   <= '0;
      pix_taken <= 1'b0;
    end else begin
      pix_taken <= 1'b0;
      if (wr_req && wr_done) begin
        wr_req    <= 1'b0;  // Drop for at least one cycle.
        pix_taken <= 1'b1;
      end else if (accept) begin
        wr_req  <= 1'b1;
        wr_addr <= addr_next;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wr_data <= pix_color;  // Held with the address.
    end
  end

  // Request, address and data hold until done.
  a_req_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req && !wr_done |=> wr_req && $stable(wr_addr) && $stable(wr_data))
    else $error("SDRAM request changed before wr_done");

  // Sequencer keeps one pixel in flight.
  a_one_in_flight: assert property (@(posedge clk) disable iff (!rst_n)
    pix_start |-> !wr_req)
    else $error("pix_start while a write is pending");

  // Writes stay inside the frame buffer.
  a_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req |-> wr_addr < pix_addr_t'(`PIXELS))
    else $error("write address 0x%0h outside frame buffer", wr_addr);

endmodule

// File: verilog/raster_counter.sv
module raster_counter (
  input  logic      clk,
  input  logic      rst_n,
  raster_if.counter rw
);

  logic [15:0] inner_len_q;
  logic [15:0] outer_len_q;
  logic [15:0] inner_idx_q;
  logic [15:0] outer_idx_q;
  logic        inner_end;
  logic        outer_end;

  // End of run and end of shape.
  assign inner_end = (inner_idx_q == inner_len_q - 16'd1);
  assign outer_end = (outer_idx_q == outer_len_q - 16'd1);

  ////////////////////////////////////////////////////////////
  // Two level index.
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inner_len_q <= 16'd0;
      outer_len_q <= 16'd0;
      inner_idx_q <= 16'd0;
      outer_idx_q <= 16'd0;
    end else if (rw.load) begin
      inner_len_q <= rw.inner_len;  // Lengths held for the shape.
      outer_len_q <= rw.outer_len;
      inner_idx_q <= 16'd0;
      outer_idx_q <= 16'd0;
    end else if (rw.step) begin
      if (inner_end) begin
        inner_idx_q <= 16'd0;                 // Wrap the run.
        outer_idx_q <= outer_idx_q + 16'd1;
      end else begin
        inner_idx_q <= inner_idx_q + 16'd1;
      end
    end
  end

  assign rw.inner_idx = inner_idx_q;
  assign rw.outer_idx = outer_idx_q;
  assign rw.last      = inner_end && outer_end;

  // Sequencer stops at the final pixel.
  a_no_step_past_end: assert property (@(posedge clk) disable iff (!rst_n)
    rw.step |-> !rw.last)
    else $error("step requested past last pixel");

endmodule

// File: verilog/raster_if.sv
// Raster walk between the sequencer and the pixel counter.
interface raster_if;

  logic        load;       // Preset both indices to zero.
  logic        step;       // Advance to next pixel.
  logic [15:0] inner_len;  // Pixels per inner run.
  logic [15:0] outer_len;  // Number of inner runs.

  logic [15:0] inner_idx;  // Position in the run.
  logic [15:0] outer_idx;  // Run number.
  logic        last;       // Final pixel of the shape.

  // Sequencer side.
  modport master (
    output load, step, inner_len, outer_len,
    input  inner_idx, outer_idx, last
  );

  // Counter side.
  modport counter (
    input  load, step, inner_len, outer_len,
    output inner_idx, outer_idx, last
  );

endinterface

// File: verilog/seg_glyph.sv
`include "draw_settings.svh"

module seg_glyph (
  input  draw_pkg::nibble_t digit,
  input  logic [4:0]        row,  // Inner index, along x.
  input  logic [3:0]        col,  // Outer index, along y.
  output logic              lit
);

  logic [6:0] seg;  // Segments a to g, a in bit 6.
  logic       row_top;
  logic       row_mid;
  logic       row_bot;
  logic       row_up;
  logic       row_lo;
  logic       col_bar;
  logic       col_left;
  logic       col_right;

  ////////////////////////////////////////////////////////////
  // Hex to seven segments.
  ////////////////////////////////////////////////////////////
  always_comb begin
    case (digit)
      4'h0:    seg = 7'b1111110;
      4'h1:    seg = 7'b0110000;
      4'h2:    seg = 7'b1101101;
      4'h3:    seg = 7'b1111001;
      4'h4:    seg = 7'b0110011;
      4'h5:    seg = 7'b1011011;
      4'h6:    seg = 7'b1011111;
      4'h7:    seg = 7'b1110000;
      4'h8:    seg = 7'b1111111;
      4'h9:    seg = 7'b1111011;
      4'hA:    seg = 7'b1110111;
      4'hB:    seg = 7'b0011111;  // Lower case b.
      4'hC:    seg = 7'b1001110;
      4'hD:    seg = 7'b0111101;  // Lower case d.
      4'hE:    seg = 7'b1001111;
      default: seg = 7'b1000111;  // F.
    endcase
  end

  // Segment regions in the 24 x 12 cell.
  assign row_top   = (row <= 5'd1);
  assign row_mid   = (row == 5'd11) || (row == 5'd12);
  assign row_bot   = (row >= 5'(`GLYPH_R - 2));
  assign row_up    = (row >= 5'd2) && (row <= 5'd10);
  assign row_lo    = (row >= 5'd13) && (row <= 5'd21);
  assign col_bar   = (col >= 4'd2) && (col <= 4'd9);
  assign col_left  = (col <= 4'd1);
  assign col_right = (col >= 4'(`GLYPH_C - 2));

  assign lit = (seg[6] && row_top && col_bar)    // a
            || (seg[5] && row_up  && col_right)  // b
            || (seg[4] && row_lo  && col_right)  // c
            || (seg[3] && row_bot && col_bar)    // d
            || (seg[2] && row_lo  && col_left)   // e
            || (seg[1] && row_up  && col_left)   // f
            || (seg[0] && row_mid && col_bar);   // g

endmodule
